/* sim.f */
+incdir+tb
design/db_pkg.sv
design/db_ram_sdp.sv
design/db_store_array.sv
design/db_cmd_front.sv
design/db_resp_buffer.sv
design/db_subsys_top.sv
tb/tb_db_subsys.sv

/* Makefile */
# Verilator build and run of the key-value store subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_db_subsys
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard tb/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a listed source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass message
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_db_checks.svh */
// Compare tasks and timeout helpers for the key-value store testbench, included inside its top module
`ifndef TB_DB_CHECKS_SVH
`define TB_DB_CHECKS_SVH

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------

    // One lookup result against the reference model
    task automatic check_resp(input string what, input db_resp_t expected, input db_resp_t actual);
        string line;
        if (actual !== expected) begin
            line = $sformatf("Mismatch in %s, %s: expected key=%h valid=%b value=%h,",
                             test_name, what, expected.key, expected.valid, expected.value);
            line = {line, $sformatf(" actual key=%h valid=%b value=%h",
                                    actual.key, actual.valid, actual.value)};
            report_failure(line);
        end
    endtask

    // Single control levels such as init_done and the handshake lines
    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("Mismatch in %s, %s: expected %b, actual %b",
                                     test_name, what, expected, actual));
        end
    endtask

    // Counted quantities like accepted lookups or sweep cycles
    task automatic check_count(input string what, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("Mismatch in %s, %s: expected %0d, actual %0d",
                                     test_name, what, expected, actual));
        end
    endtask

    // ----------------------------------------
    // Timeout helper
    // ----------------------------------------

    // Every polling loop calls this once per cycle it has waited
    task automatic check_timeout(input int waited, input int limit, input string what);
        if (waited >= limit) begin
            report_failure($sformatf("Timeout in %s after %0d cycles: %s",
                                     test_name, waited, what));
        end
    endtask

`endif

/* tb/tb_db_subsys.sv */
// Testbench for the key-value store subsystem, run as the simulation top with random host traffic
`timescale 1ns/10ps

module tb_db_subsys;

    import db_pkg::*;

    localparam int          NKEYS       = 2 ** KEY_WID;
    localparam int          CMD_TIMEOUT = 300;
    localparam int          RSP_TIMEOUT = 300;
    localparam int          RUN_LIMIT   = 50000;
    localparam logic [31:0] SEED        = 32'hd469_4594;

    logic     clk;
    logic     rst_n;
    logic     init;
    logic     init_done;
    logic     cmd_req;
    db_cmd_t  cmd;
    logic     cmd_ack;
    logic     resp_req;
    db_resp_t resp;
    logic     resp_ack;

    // Reference model with one record per key
    logic     model_valid [NKEYS];
    value_t   model_value [NKEYS];
    // Expected lookup results in command order, consumed through resp_count
    db_resp_t exp_q [$];
    int       resp_count;
    int       lookups_issued;

    logic [31:0] host_rng;
    logic [31:0] resp_rng;
    string       test_name;
    // Response side controls set by the main sequence
    logic        hold_acks;
    int          max_ack_delay;

    db_subsys_top #(
        .DEPTH (RESP_DEPTH)
    ) i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (init),
        .init_done (init_done),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .resp_req  (resp_req),
        .resp      (resp),
        .resp_ack  (resp_ack)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    `include "tb_db_checks.svh"

    // Numerical Recipes constants, upper bits are the useful ones
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < NKEYS; i++) begin
            model_valid[i] = 1'b0;
            model_value[i] = '0;
        end
    endfunction

    // ----------------------------------------
    // Host command side
    // ----------------------------------------

    // Full four-phase cycle, with the model updated when cmd_ack rises
    task automatic issue_cmd(input db_op_e op, input key_t key, input value_t value);
        db_cmd_t  c;
        db_resp_t e;
        int       waited;
        c.op    = op;
        c.key   = key;
        c.value = value;
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        @(negedge clk);
        waited = 0;
        while (!cmd_ack) begin
            waited++;
            check_timeout(waited, CMD_TIMEOUT, "cmd_ack never rose for a command");
            @(negedge clk);
        end
        check_bit("store ready at acknowledge", 1'b1, init_done);
        case (op)
            DB_OP_WRITE: begin
                model_valid[key] = 1'b1;
                model_value[key] = value;
            end
            DB_OP_DELETE: begin
                model_valid[key] = 1'b0;
                model_value[key] = '0;
            end
            default: begin
                e.key   = key;
                e.valid = model_valid[key];
                e.value = model_value[key];
                exp_q.push_back(e);
                lookups_issued++;
            end
        endcase
        @(posedge clk);
        cmd_req <= 1'b0;
        @(negedge clk);
        waited = 0;
        while (cmd_ack) begin
            waited++;
            check_timeout(waited, CMD_TIMEOUT, "cmd_ack never fell after cmd_req dropped");
            @(negedge clk);
        end
    endtask

    task automatic read_all_keys();
        for (int i = 0; i < NKEYS; i++) begin
            issue_cmd(DB_OP_READ, key_t'(i), '0);
        end
    endtask

    // Counts the cycles seen with init_done low, starting at the next falling edge
    task automatic wait_init_done(output int low_cycles);
        low_cycles = 0;
        @(negedge clk);
        while (!init_done) begin
            low_cycles++;
            check_timeout(low_cycles, 4 * NKEYS, "init_done did not rise after the sweep");
            @(negedge clk);
        end
    endtask

    task automatic pulse_init();
        @(posedge clk);
        init <= 1'b1;
        @(posedge clk);
        init <= 1'b0;
        clear_model();
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        @(negedge clk);
        while (resp_count != exp_q.size() || resp_req || resp_ack) begin
            waited++;
            check_timeout(waited, RSP_TIMEOUT, "lookup responses did not drain");
            @(negedge clk);
        end
    endtask

    // ----------------------------------------
    // Host response side
    // ----------------------------------------

    initial begin : responder
        int delay;
        int waited;
        resp_ack   <= 1'b0;
        resp_count = 0;
        resp_rng   = lcg_next(~SEED);
        forever begin
            @(negedge clk);
            if (resp_req && !resp_ack) begin
                if (resp_count >= exp_q.size()) begin
                    report_failure("A response arrived with no lookup outstanding");
                end
                waited = 0;
                while (hold_acks) begin
                    waited++;
                    check_timeout(waited, RSP_TIMEOUT, "response acknowledge stayed on hold");
                    @(negedge clk);
                end
                resp_rng = lcg_next(resp_rng);
                delay    = int'(resp_rng[30:28]) % (max_ack_delay + 1);
                repeat (delay) @(negedge clk);
                // The entry must still be offered, unchanged, right before the ack
                check_bit("resp_req held until acknowledge", 1'b1, resp_req);
                check_resp("lookup response", exp_q[resp_count], resp);
                resp_count++;
                @(posedge clk);
                resp_ack <= 1'b1;
                @(negedge clk);
                waited = 0;
                while (resp_req) begin
                    waited++;
                    check_timeout(waited, RSP_TIMEOUT, "resp_req did not fall after resp_ack");
                    @(negedge clk);
                end
                @(posedge clk);
                resp_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        report_failure("The run did not finish within the cycle limit");
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : main
        int low_cycles;
        int base;
        rst_n          <= 1'b0;
        init           <= 1'b0;
        cmd_req        <= 1'b0;
        cmd            <= '0;
        hold_acks      = 1'b0;
        max_ack_delay  = 2;
        lookups_issued = 0;
        host_rng       = SEED;
        test_name      = "reset";
        clear_model();
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_bit("cmd_ack in reset", 1'b0, cmd_ack);
        check_bit("resp_req in reset", 1'b0, resp_req);
        check_bit("init_done in reset", 1'b0, init_done);
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Every key is empty once the first sweep is over
        test_name = "empty_after_reset";
        wait_init_done(low_cycles);
        read_all_keys();
        wait_drained();

        test_name = "random_write_read";
        for (int i = 0; i < 300; i++) begin
            host_rng = lcg_next(host_rng);
            if (host_rng[31]) begin
                issue_cmd(DB_OP_WRITE, host_rng[29:24], host_rng[23:8]);
            end else begin
                issue_cmd(DB_OP_READ, host_rng[29:24], '0);
            end
        end
        read_all_keys();
        wait_drained();

        // The delete carries a random value that the store has to ignore
        test_name = "delete_then_read";
        for (int i = 0; i < 16; i++) begin
            host_rng = lcg_next(host_rng);
            issue_cmd(DB_OP_DELETE, host_rng[29:24], host_rng[23:8]);
            issue_cmd(DB_OP_READ, host_rng[29:24], '0);
        end
        read_all_keys();
        wait_drained();

        // A lookup started during the sweep waits for init_done
        test_name = "init_in_mid_run";
        for (int i = 0; i < 16; i++) begin
            host_rng = lcg_next(host_rng);
            issue_cmd(DB_OP_WRITE, host_rng[29:24], host_rng[23:8]);
        end
        pulse_init();
        fork
            begin
                wait_init_done(low_cycles);
                check_count("clearing sweep length", NKEYS, low_cycles);
            end
            issue_cmd(DB_OP_READ, host_rng[29:24], '0);
        join
        read_all_keys();
        wait_drained();

        // With acks on hold the buffer fills and further lookups stall
        test_name     = "response_backpressure";
        hold_acks     = 1'b1;
        max_ack_delay = 7;
        base          = lookups_issued;
        fork
            for (int i = 0; i < RESP_DEPTH + 4; i++) begin
                host_rng = lcg_next(host_rng);
                issue_cmd(DB_OP_READ, host_rng[29:24], '0);
            end
            begin
                repeat (40) @(negedge clk);
                check_count("lookups accepted with a full buffer", RESP_DEPTH,
                            lookups_issued - base);
                check_bit("cmd_ack held off with a full buffer", 1'b0, cmd_ack);
                hold_acks = 1'b0;
            end
        join
        for (int i = 0; i < 40; i++) begin
            host_rng = lcg_next(host_rng);
            if (host_rng[31]) begin
                issue_cmd(DB_OP_WRITE, host_rng[29:24], host_rng[23:8]);
            end else begin
                issue_cmd(DB_OP_READ, host_rng[29:24], '0);
            end
        end
        wait_drained();

        test_name = "end_of_run";
        repeat (10) @(negedge clk);
        if (resp_count == exp_q.size() && !resp_req) begin
            $display("Regression passed");
            $finish;
        end else begin
            report_failure("Lookup responses were still outstanding at the end of the run");
        end
    end

endmodule

/* design/db_subsys_top.sv */
// Top level of the key-value store subsystem that joins the front end, store and response buffer
`timescale 1ns/10ps

module db_subsys_top #(
    parameter int DEPTH = db_pkg::RESP_DEPTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init,
    output logic             init_done,
    input  logic             cmd_req,
    input  db_pkg::db_cmd_t  cmd,
    output logic             cmd_ack,
    output logic             resp_req,
    output db_pkg::db_resp_t resp,
    input  logic             resp_ack
);

    import db_pkg::*;

    // ----------------------------------------
    // Internal connections
    // ----------------------------------------

    // Front end to store
    logic     wr_en;
    db_wr_t   wr;
    logic     rd_en;
    key_t     rd_key;

    // Store to response buffer
    logic     rd_valid;
    db_resp_t rd_resp;

    // Buffer room reported back to the front end
    logic     space;

    db_cmd_front u_cmd_front (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .init_done (init_done),
        .space     (space),
        .wr_en     (wr_en),
        .wr        (wr),
        .rd_en     (rd_en),
        .rd_key    (rd_key)
    );

    // Valid tracking is on so deleted keys read back as empty
    db_store_array #(
        .KEY_T       (key_t),
        .VALUE_T     (value_t),
        .TRACK_VALID (1'b1)
    ) u_store_array (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (init),
        .init_done (init_done),
        .wr_en     (wr_en),
        .wr        (wr),
        .rd_en     (rd_en),
        .rd_key    (rd_key),
        .rd_valid  (rd_valid),
        .rd_resp   (rd_resp)
    );

    db_resp_buffer #(
        .DEPTH (DEPTH)
    ) u_resp_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rd_valid),
        .push_data (rd_resp),
        .space     (space),
        .resp_req  (resp_req),
        .resp      (resp),
        .resp_ack  (resp_ack)
    );

endmodule

/* design/db_resp_buffer.sv */
// FIFO of lookup results that hands each entry back to the host over four-phase req/ack
`timescale 1ns/10ps

module db_resp_buffer #(
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  db_pkg::db_resp_t push_data,
    output logic             space,
    output logic             resp_req,
    output db_pkg::db_resp_t resp,
    input  logic             resp_ack
);

    import db_pkg::*;

    // DEPTH must be at least two for the pointer width to make sense
    localparam int PTR_WID = $clog2(DEPTH);
    localparam int CNT_WID = $clog2(DEPTH + 1);

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_REQ,
        RS_DROP
    } rstate_e;

    rstate_e              rstate;
    logic [PTR_WID-1:0]   wr_ptr;
    logic [PTR_WID-1:0]   rd_ptr;
    logic [CNT_WID-1:0]   count;
    logic                 pop;

    db_resp_t             mem [DEPTH];

    // ----------------------------------------
    // Occupancy
    // ----------------------------------------

    // A result arriving this cycle is not yet in count
    // It is added here so a new lookup is only taken with a slot to spare
    assign space = (int'(count) + int'(push)) < DEPTH;

    // The head leaves when the host acknowledges it
    assign pop = (rstate == RS_REQ) && resp_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WID'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WID'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // ----------------------------------------
    // Host response handshake
    // ----------------------------------------

    // REQ offers the head, DROP waits for the host to release resp_ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rstate <= RS_IDLE;
        end else begin
            case (rstate)
                RS_IDLE: if (count != '0) rstate <= RS_REQ;
                RS_REQ:  if (resp_ack) rstate <= RS_DROP;
                RS_DROP: if (!resp_ack) rstate <= RS_IDLE;
                default: rstate <= RS_IDLE;
            endcase
        end
    end

    assign resp_req = (rstate == RS_REQ);

    // The head only moves on a pop, so resp is stable while resp_req is high
    assign resp = mem[rd_ptr];

    // The front end holds off lookups early enough that nothing overflows
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (int'(count) < DEPTH)
    );

endmodule

/* design/db_cmd_front.sv */
// Command front end that takes host commands over four-phase req/ack and issues them to the store
`timescale 1ns/10ps

module db_cmd_front (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cmd_req,
    input  db_pkg::db_cmd_t cmd,
    output logic            cmd_ack,
    input  logic            init_done,
    input  logic            space,
    output logic            wr_en,
    output db_pkg::db_wr_t  wr,
    output logic            rd_en,
    output db_pkg::key_t    rd_key
);

    import db_pkg::*;

    // IDLE waits for a request and ACK holds the acknowledge until it drops
    typedef enum logic {
        ST_IDLE,
        ST_ACK
    } state_e;

    state_e state;
    logic   is_read;
    logic   go;

    // ----------------------------------------
    // Issue decision
    // ----------------------------------------

    assign is_read = (cmd.op == DB_OP_READ);

    // A command goes out once the store is ready
    // A lookup also needs a buffer slot for its result
    assign go = (state == ST_IDLE) && cmd_req && init_done && (!is_read || space);

    // Writes and deletes share the write path
    assign wr_en = go && !is_read;
    assign rd_en = go && is_read;

    // Acknowledge rises in the issue cycle and holds through ACK
    assign cmd_ack = go || (state == ST_ACK);

    // A delete stores an empty record with a zero value
    always_comb begin
        wr.key   = cmd.key;
        wr.valid = (cmd.op == DB_OP_WRITE);
        wr.value = (cmd.op == DB_OP_WRITE) ? cmd.value : '0;
    end

    assign rd_key = cmd.key;

    // ----------------------------------------
    // Handshake FSM
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (go) begin
                        state <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // The host has seen the acknowledge once it drops cmd_req
                    if (!cmd_req) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // The acknowledge holds for as long as the host keeps its request up
    a_ack_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(cmd_ack) |-> !cmd_req
    );

    // Every issue opens a new handshake, so no command goes out twice
    a_single_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en || rd_en) |-> !$past(cmd_ack)
    );

endmodule

/* design/db_store_array.sv */
// Record store that maps key writes and lookups onto the clearing RAM and returns keyed results
`timescale 1ns/10ps

module db_store_array #(
    parameter type KEY_T       = logic [5:0],
    parameter type VALUE_T     = logic [15:0],
    parameter bit  TRACK_VALID = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             init,
    output logic             init_done,
    input  logic             wr_en,
    input  db_pkg::db_wr_t   wr,
    input  logic             rd_en,
    input  KEY_T             rd_key,
    output logic             rd_valid,
    output db_pkg::db_resp_t rd_resp
);

    localparam int KEY_WID   = $bits(KEY_T);
    localparam int VALUE_WID = $bits(VALUE_T);
    // One extra bit per entry holds the valid flag
    localparam int ENTRY_WID = TRACK_VALID ? VALUE_WID + 1 : VALUE_WID;

    logic [KEY_WID-1:0]   ram_wr_addr;
    logic [ENTRY_WID-1:0] ram_wr_data;
    logic [ENTRY_WID-1:0] ram_rd_data;

    // Key of the lookup whose data is on ram_rd_data
    KEY_T   rd_key_q;
    logic   rd_rec_valid;
    VALUE_T rd_value;

    // ----------------------------------------
    // Record RAM
    // ----------------------------------------

    db_ram_sdp #(
        .ADDR_WID (KEY_WID),
        .DATA_WID (ENTRY_WID)
    ) u_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .init      (init),
        .wr_en     (wr_en),
        .wr_addr   (ram_wr_addr),
        .wr_data   (ram_wr_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_key),
        .rd_data   (ram_rd_data),
        .init_done (init_done)
    );

    // The key is the RAM address directly since there is no hashing
    assign ram_wr_addr = KEY_T'(wr.key);

    generate
        if (TRACK_VALID) begin : g_valid_tracked
            // Valid sits above the value in each entry
            assign ram_wr_data = {wr.valid, VALUE_T'(wr.value)};
            assign {rd_rec_valid, rd_value} = ram_rd_data;
        end else begin : g_valid_untracked
            // Without a flag every record reads back as present
            assign ram_wr_data  = VALUE_T'(wr.value);
            assign rd_rec_valid = 1'b1;
            assign rd_value     = ram_rd_data;
        end
    endgenerate

    // ----------------------------------------
    // Lookup response
    // ----------------------------------------

    // The key is captured next to the RAM read so the result names its key
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_key_q <= rd_key;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    assign rd_resp.key   = rd_key_q;
    assign rd_resp.valid = rd_rec_valid;
    assign rd_resp.value = rd_value;

    // Lookups during a sweep would return half-cleared data
    a_no_rd_before_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |-> init_done
    );

endmodule

/* design/db_ram_sdp.sv */
// Simple dual-port RAM with registered read data and a self-clearing sweep on reset or init
`timescale 1ns/10ps

module db_ram_sdp #(
    parameter int ADDR_WID = 6,
    parameter int DATA_WID = 17
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                init,
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [DATA_WID-1:0] wr_data,
    input  logic                rd_en,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [DATA_WID-1:0] rd_data,
    output logic                init_done
);

    // Every address is swept once, so the sweep lasts DEPTH cycles
    localparam int DEPTH = 2 ** ADDR_WID;

    typedef enum logic {
        ST_SWEEP,
        ST_READY
    } state_e;

    state_e              state;
    logic [ADDR_WID-1:0] clr_addr;

    // Write port after the sweep has been merged in
    logic                mem_we;
    logic [ADDR_WID-1:0] mem_addr;
    logic [DATA_WID-1:0] mem_data;

    logic [DATA_WID-1:0] mem [DEPTH];

    // ----------------------------------------
    // Clearing FSM
    // ----------------------------------------

    // Reset and init both restart the sweep from address zero
    // An init that arrives during a sweep starts it over
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_SWEEP;
            clr_addr <= '0;
        end else if (init) begin
            state    <= ST_SWEEP;
            clr_addr <= '0;
        end else if (state == ST_SWEEP) begin
            clr_addr <= clr_addr + 1'b1;
            // The last address is cleared in this cycle
            if (clr_addr == ADDR_WID'(DEPTH - 1)) begin
                state <= ST_READY;
            end
        end
    end

    // The store is usable only once every address holds zero
    assign init_done = (state == ST_READY);

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // The sweep owns the write port while it runs
    assign mem_we   = (state == ST_SWEEP) || wr_en;
    assign mem_addr = (state == ST_SWEEP) ? clr_addr : wr_addr;
    assign mem_data = (state == ST_SWEEP) ? '0 : wr_data;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_data;
        end
    end

    // Read data appears one cycle after rd_en and then holds
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // The front end has to stay off the write port for the whole sweep
    a_no_wr_in_sweep: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == ST_SWEEP) |-> !wr_en
    );

endmodule

/* design/db_pkg.sv */
// Shared types and sizes for the key-value store subsystem, imported by every design unit
package db_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    // Six key bits give a 64-entry store, so the clearing sweep stays short
    localparam int KEY_WID = 6;

    // Width of the payload carried by each record
    localparam int VALUE_WID = 16;

    // Default number of lookup results the response buffer can hold
    localparam int RESP_DEPTH = 4;

    // ----------------------------------------
    // Record and command types
    // ----------------------------------------

    typedef logic [KEY_WID-1:0]   key_t;
    typedef logic [VALUE_WID-1:0] value_t;

    // Host command opcodes, where the encoding 2'b11 is unused
    typedef enum logic [1:0] {
        DB_OP_WRITE  = 2'd0,
        DB_OP_DELETE = 2'd1,
        DB_OP_READ   = 2'd2
    } db_op_e;

    // One host command word
    // The value field only matters for a write
    typedef struct packed {
        db_op_e op;
        key_t   key;
        value_t value;
    } db_cmd_t;

    // Write word from the front end to the store
    // A delete is a write with valid low and a zero value
    typedef struct packed {
        key_t   key;
        value_t value;
        logic   valid;
    } db_wr_t;

    // One lookup result as it is returned to the host
    typedef struct packed {
        key_t   key;
        logic   valid;
        value_t value;
    } db_resp_t;

endpackage
